/* verif/global_controller_input.txt */
# test op(1 write 0 read) data_type addr(hex) wdata(hex) ready_mask(hex) delay(cycles)
# one request per line, lines of a test are consecutive
1 1 0 012340 a5a50001 f 0
1 1 1 02a461 5a5a0002 f 0
1 1 0 3fff3e 12345678 f 0
1 1 1 1000b3 cafe0004 f 0
2 1 0 000104 11110000 e 0
2 0 1 02a461 00000000 d 2
2 1 1 000207 22220000 7 0
3 0 0 012340 00000000 f 12
3 0 1 02a461 00000000 f 8
3 0 0 3fff3e 00000000 f 4
3 0 1 1000b3 00000000 f 0
3 0 0 000555 00000000 f 6
3 0 0 00aaa2 00000000 f 1
3 0 0 012340 00000000 f 3
3 0 1 000104 00000000 f 0
3 0 0 000207 00000000 f 2
4 0 0 001000 00000000 f 30
4 0 0 001001 00000000 f 30
4 0 0 001002 00000000 f 30
4 0 0 001003 00000000 f 30
4 0 1 001004 00000000 f 30
4 0 1 001005 00000000 f 30
4 0 1 001006 00000000 f 30
4 0 1 001007 00000000 f 30
4 0 0 001008 00000000 f 30
4 0 0 001009 00000000 f 30
4 0 0 00100a 00000000 f 30
4 0 0 00100b 00000000 f 30
4 0 1 00100c 00000000 f 30
4 0 1 00100d 00000000 f 30
4 0 1 00100e 00000000 f 30
4 0 1 00100f 00000000 f 30
4 1 0 001004 44440004 f 0
5 1 0 0020f1 01010101 f 0
5 1 1 0020f1 02020202 f 0
5 0 0 0020f1 00000000 f 1
5 0 1 001004 00000000 f 0
5 0 0 3abcd2 00000000 f 2
5 1 0 0020f5 05050505 f 0
5 0 0 0020f5 00000000 f 0
5 0 0 0020f1 00000000 f 3

/* compile.f */
source/dram_ctrl_pkg.sv
source/command_dispatch.sv
source/read_order_fifo.sv
source/read_return_mux.sv
source/global_controller.sv
verif/global_controller_sva.sv
verif/tb_global_controller.sv

/* Bender.yml */
package:
  name: dram_global_controller

sources:
  - source/dram_ctrl_pkg.sv
  - source/command_dispatch.sv
  - source/read_order_fifo.sv
  - source/read_return_mux.sv
  - source/global_controller.sv
  - target: simulation
    files:
      - verif/global_controller_sva.sv
      - verif/tb_global_controller.sv

/* verif/tb_global_controller.sv */
module tb_global_controller;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ORDER_DEPTH  = 16;
    localparam int NB           = dram_ctrl_pkg::NUM_BANKS;
    // cycles a request sits on a not-ready bank before all banks open up
    localparam int STALL_CYCLES = 3;

    // one stimulus line
    typedef struct packed {
        int          test_no;
        logic        op;
        logic        data_type;
        logic [21:0] addr;
        logic [31:0] wdata;
        logic [3:0]  ready_mask;
        int          delay;
    } vector_t;

    logic                                     i_clk;
    logic                                     i_rst_n;
    logic                                     i_command_valid;
    dram_ctrl_pkg::frontend_command_t         i_command;
    dram_ctrl_pkg::word_t                     i_write_data;
    logic                                     o_controller_ready;
    logic                                     o_read_data_valid;
    dram_ctrl_pkg::word_t                     o_read_data;
    logic [NB-1:0]                            i_bank_ready;
    logic [NB-1:0]                            o_bank_cmd_valid;
    dram_ctrl_pkg::backend_command_t [NB-1:0] o_bank_cmd;
    dram_ctrl_pkg::word_t [NB-1:0]            o_bank_wdata;
    logic [NB-1:0]                            o_bank_ren;
    logic [NB-1:0]                            i_bank_rdata_valid;
    dram_ctrl_pkg::word_t [NB-1:0]            i_bank_rdata;

    vector_t     vectors[$];
    // request currently offered
    vector_t     cur;
    logic        loaded;
    logic        req_done;
    int          cycle;
    int          error_count;
    int          tests_run;
    int          tests_failed;
    // expected read data and bank, oldest first
    logic [31:0] sb_data[$];
    logic [1:0]  sb_bank[$];
    // front-end memory image built from the file
    logic [31:0] ref_mem[int];
    // bank models, storage and pending responses
    logic [31:0] bank_mem[NB][int];
    logic [31:0] resp_data[NB][$];
    int          resp_due[NB][$];

    global_controller #(.ORDER_DEPTH(ORDER_DEPTH)) dut_i
    (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .i_command_valid    (i_command_valid),
        .i_command          (i_command),
        .i_write_data       (i_write_data),
        .o_controller_ready (o_controller_ready),
        .o_read_data_valid  (o_read_data_valid),
        .o_read_data        (o_read_data),
        .i_bank_ready       (i_bank_ready),
        .o_bank_cmd_valid   (o_bank_cmd_valid),
        .o_bank_cmd         (o_bank_cmd),
        .o_bank_wdata       (o_bank_wdata),
        .o_bank_ren         (o_bank_ren),
        .i_bank_rdata_valid (i_bank_rdata_valid),
        .i_bank_rdata       (i_bank_rdata)
    );

    bind global_controller global_controller_sva sva_i
    (
        .i_clk             (i_clk),
        .i_command_valid   (i_command_valid),
        .i_bank_cmd_valid  (o_bank_cmd_valid),
        .i_bank_ren        (o_bank_ren),
        .i_read_data_valid (o_read_data_valid)
    );

    initial
    begin
        i_clk = 1'b0;
    end

    always #10 i_clk = ~i_clk;

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    // never-written locations read back as the inverted address
    function automatic logic [31:0] unwritten_word(input logic [21:0] addr);
        return ~{10'h0, addr};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("Error: %s = 0x%h, expected 0x%h at %0t ns", name, got, exp, $time);
            error_count++;
        end
    endtask

    task automatic report_test(input int test_no, input int errs);
        tests_run++;
        if (errs == 0)
        begin
            $display("test %0d: passed", test_no);
        end
        else
        begin
            tests_failed++;
            $display("test %0d: failed with %0d errors", test_no, errs);
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        int          t_no;
        int          op;
        int          dt;
        int          delay;
        string       line;
        logic [21:0] addr;
        logic [31:0] wdata;
        logic [3:0]  mask;
        vector_t     v;
        fd = $fopen("verif/global_controller_input.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the stimulus file verif/global_controller_input.txt");
            error_count++;
            return;
        end
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            // skip blanks and comment lines
            if (line.len() == 0 || line[0] == "#")
            begin
                continue;
            end
            n = $sscanf(line, "%d %d %d %h %h %h %d", t_no, op, dt, addr, wdata, mask, delay);
            if (n == 7)
            begin
                v.test_no    = t_no;
                v.op         = op[0];
                v.data_type  = dt[0];
                v.addr       = addr;
                v.wdata      = wdata;
                v.ready_mask = mask;
                v.delay      = delay;
                vectors.push_back(v);
            end
        end
        $fclose(fd);
        if (vectors.size() == 0)
        begin
            $display("the stimulus file holds no usable vectors");
            error_count++;
        end
    endtask

    // bank model takes a command off its channel
    task automatic bank_take_command(input int b);
        logic [19:0] key;
        key = {o_bank_cmd[b].row_addr, o_bank_cmd[b].col_addr};
        if (o_bank_cmd[b].op == dram_ctrl_pkg::OP_WRITE)
        begin
            bank_mem[b][key] = o_bank_wdata[b];
        end
        else
        begin
            resp_data[b].push_back(bank_mem[b].exists(key) ? bank_mem[b][key]
                                                           : unwritten_word({key, 2'(b)}));
            // file delay plus 0..3 random cycles
            resp_due[b].push_back(cycle + cur.delay + int'($urandom % 4));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // bank return drivers
    ////////////////////////////////////////////////////////////

    always @(posedge i_clk)
    begin
        #2;
        cycle++;
        for (int b = 0; b < NB; b++)
        begin
            if (resp_due[b].size() > 0 && resp_due[b][0] <= cycle)
            begin
                i_bank_rdata_valid[b] = 1'b1;
                i_bank_rdata[b]       = resp_data[b][0];
            end
            else
            begin
                // junk on an idle channel
                i_bank_rdata_valid[b] = 1'b0;
                i_bank_rdata[b]       = $urandom;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // monitor, mid-cycle where everything is settled
    ////////////////////////////////////////////////////////////

    always @(negedge i_clk)
    begin : monitor
        logic [1:0]    bank;
        logic          exp_accept;
        logic          exp_rdv;
        logic [NB-1:0] exp_ren;
        string         lane;
        bank       = cur.addr[1:0];
        // queue occupancy equals the scoreboard depth at this point
        exp_accept = i_rst_n && i_command_valid && i_bank_ready[bank]
                     && (sb_data.size() < ORDER_DEPTH);
        exp_ren    = '0;
        if (i_rst_n && sb_bank.size() > 0)
        begin
            exp_ren[sb_bank[0]] = 1'b1;
        end
        exp_rdv = |(exp_ren & i_bank_rdata_valid);

        check_value("o_controller_ready", o_controller_ready, exp_accept);
        check_value("o_bank_cmd_valid", o_bank_cmd_valid, exp_accept ? NB'(1) << bank : '0);
        check_value("o_bank_ren", o_bank_ren, exp_ren);
        check_value("o_read_data_valid", o_read_data_valid, exp_rdv);
        if (exp_rdv)
        begin
            check_value("o_read_data", o_read_data, sb_data[0]);
            void'(sb_data.pop_front());
            void'(sb_bank.pop_front());
        end
        else
        begin
            check_value("o_read_data", o_read_data, '0);
        end

        // bank side handshakes
        for (int b = 0; b < NB; b++)
        begin
            if (o_bank_ren[b] && i_bank_rdata_valid[b])
            begin
                void'(resp_data[b].pop_front());
                void'(resp_due[b].pop_front());
            end
            if (o_bank_cmd_valid[b] && i_bank_ready[b])
            begin
                bank_take_command(b);
            end
        end

        // accepted request, every lane carries the reshaped command
        if (exp_accept && o_controller_ready)
        begin
            for (int b = 0; b < NB; b++)
            begin
                lane = $sformatf("[%0d]", b);
                check_value({"o_bank_cmd", lane, ".op"}, o_bank_cmd[b].op, cur.op);
                check_value({"o_bank_cmd", lane, ".data_type"}, o_bank_cmd[b].data_type,
                            cur.data_type);
                check_value({"o_bank_cmd", lane, ".row_addr"}, o_bank_cmd[b].row_addr,
                            cur.addr[21:6]);
                check_value({"o_bank_cmd", lane, ".col_addr"}, o_bank_cmd[b].col_addr,
                            cur.addr[5:2]);
                check_value({"o_bank_wdata", lane}, o_bank_wdata[b], cur.wdata);
            end
            if (cur.op)
            begin
                ref_mem[cur.addr] = cur.wdata;
            end
            else
            begin
                sb_data.push_back(ref_mem.exists(cur.addr) ? ref_mem[cur.addr]
                                                           : unwritten_word(cur.addr));
                sb_bank.push_back(bank);
            end
            req_done = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    initial
    begin
        int start_errors;
        int held;
        void'($urandom(2168));
        i_rst_n            = 1'b0;
        i_command_valid    = 1'b0;
        i_command          = '0;
        i_write_data       = '0;
        i_bank_ready       = '0;
        i_bank_rdata_valid = '0;
        i_bank_rdata       = '0;
        cur                = '0;
        req_done           = 1'b0;
        cycle              = 0;
        error_count        = 0;
        tests_run          = 0;
        tests_failed       = 0;
        loaded             = 1'b0;
        load_vectors();
        loaded       = 1'b1;
        start_errors = error_count;

        // a request offered late in reset must be ignored
        repeat (7) @(posedge i_clk);
        #2;
        i_command_valid = 1'b1;
        i_bank_ready    = '1;
        repeat (3) @(posedge i_clk);
        #2;
        i_rst_n         = 1'b1;
        i_command_valid = 1'b0;
        repeat (3) @(posedge i_clk);
        report_test(0, error_count - start_errors);
        start_errors = error_count;

        for (int i = 0; i < vectors.size(); i++)
        begin
            #2;
            cur                 = vectors[i];
            i_command_valid     = 1'b1;
            i_command.op        = dram_ctrl_pkg::op_e'(cur.op);
            i_command.data_type = dram_ctrl_pkg::data_type_e'(cur.data_type);
            i_command.addr      = cur.addr;
            i_write_data        = cur.wdata;
            i_bank_ready        = cur.ready_mask;
            req_done            = 1'b0;
            held                = 0;
            @(posedge i_clk);
            // hold until the monitor saw the transfer
            while (!req_done)
            begin
                held++;
                if (held == STALL_CYCLES)
                begin
                    #2;
                    i_bank_ready = '1;
                end
                @(posedge i_clk);
            end
            // last line of a test, drain reads and report
            if (i == vectors.size() - 1 || vectors[i + 1].test_no != cur.test_no)
            begin
                #2;
                i_command_valid = 1'b0;
                while (sb_data.size() != 0)
                begin
                    @(posedge i_clk);
                end
                @(posedge i_clk);
                report_test(cur.test_no, error_count - start_errors);
                start_errors = error_count;
            end
        end

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0)
        begin
            $display("Simulation PASSED");
        end
        else
        begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // run limit scales with the number of vectors
    initial
    begin : watchdog
        longint limit_ns;
        wait (loaded === 1'b1);
        limit_ns = longint'(vectors.size()) * (ORDER_DEPTH + 8) * 20;
        #(limit_ns * 1ns);
        $display("timeout: the run did not finish within %0d ns", limit_ns);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* verif/global_controller_sva.sv */
module global_controller_sva
(
    input logic                                i_clk,
    input logic                                i_command_valid,
    input logic [dram_ctrl_pkg::NUM_BANKS-1:0] i_bank_cmd_valid,
    input logic [dram_ctrl_pkg::NUM_BANKS-1:0] i_bank_ren,
    input logic                                i_read_data_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    ////////////////////////////////////////////////////////////
    // handshake rules
    ////////////////////////////////////////////////////////////

    // one target bank per request
    cmd_valid_onehot: assert property (@(posedge i_clk) $onehot0(i_bank_cmd_valid))
        else $error("more than one bank command valid");

    // only the oldest read's bank is enabled
    ren_onehot: assert property (@(posedge i_clk) $onehot0(i_bank_ren))
        else $error("more than one bank return enable");

    // read data needs an enabled bank
    rdata_needs_ren: assert property (@(posedge i_clk) i_read_data_valid |-> |i_bank_ren)
        else $error("read data valid without a return enable");

    // bank valid never without a front-end request
    valid_needs_request: assert property
        (@(posedge i_clk) |i_bank_cmd_valid |-> i_command_valid)
        else $error("bank command valid without a request");

endmodule

/* source/global_controller.sv */
module global_controller
#(
    parameter int ORDER_DEPTH = 16
)
(
    input  logic                                                   i_clk,
    input  logic                                                   i_rst_n,
    // request channel
    input  logic                                                   i_command_valid,
    input  dram_ctrl_pkg::frontend_command_t                       i_command,
    input  dram_ctrl_pkg::word_t                                   i_write_data,
    output logic                                                   o_controller_ready,
    // read data channel
    output logic                                                   o_read_data_valid,
    output dram_ctrl_pkg::word_t                                   o_read_data,
    // bank command channels
    input  logic [dram_ctrl_pkg::NUM_BANKS-1:0]                    i_bank_ready,
    output logic [dram_ctrl_pkg::NUM_BANKS-1:0]                    o_bank_cmd_valid,
    output dram_ctrl_pkg::backend_command_t [dram_ctrl_pkg::NUM_BANKS-1:0] o_bank_cmd,
    output dram_ctrl_pkg::word_t [dram_ctrl_pkg::NUM_BANKS-1:0]    o_bank_wdata,
    // bank return channels
    output logic [dram_ctrl_pkg::NUM_BANKS-1:0]                    o_bank_ren,
    input  logic [dram_ctrl_pkg::NUM_BANKS-1:0]                    i_bank_rdata_valid,
    input  dram_ctrl_pkg::word_t [dram_ctrl_pkg::NUM_BANKS-1:0]    i_bank_rdata
);

    // read-order queue hookup
    logic                     order_push;
    dram_ctrl_pkg::bank_idx_t order_bank;
    logic                     order_pop;
    dram_ctrl_pkg::bank_idx_t head_bank;
    logic                     order_empty;
    logic                     order_full;

    ////////////////////////////////////////////////////////////
    // request to bank steering
    ////////////////////////////////////////////////////////////

    command_dispatch dispatch_i
    (
        .i_rst_n            (i_rst_n),
        .i_command_valid    (i_command_valid),
        .i_command          (i_command),
        .i_write_data       (i_write_data),
        .i_bank_ready       (i_bank_ready),
        .i_order_full       (order_full),
        .o_controller_ready (o_controller_ready),
        .o_bank_cmd_valid   (o_bank_cmd_valid),
        .o_bank_cmd         (o_bank_cmd),
        .o_bank_wdata       (o_bank_wdata),
        .o_order_push       (order_push),
        .o_order_bank       (order_bank)
    );

    // issue order of outstanding reads
    read_order_fifo #(.ORDER_DEPTH(ORDER_DEPTH)) order_fifo_i
    (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_push      (order_push),
        .i_push_bank (order_bank),
        .i_pop       (order_pop),
        .o_head_bank (head_bank),
        .o_empty     (order_empty),
        .o_full      (order_full)
    );

    // in-order return path
    read_return_mux return_mux_i
    (
        .i_rst_n            (i_rst_n),
        .i_head_bank        (head_bank),
        .i_empty            (order_empty),
        .i_bank_rdata_valid (i_bank_rdata_valid),
        .i_bank_rdata       (i_bank_rdata),
        .o_bank_ren         (o_bank_ren),
        .o_read_data_valid  (o_read_data_valid),
        .o_read_data        (o_read_data),
        .o_pop              (order_pop)
    );

endmodule

/* source/read_return_mux.sv */
module read_return_mux
(
    input  logic                                                i_rst_n,
    // head of the read-order queue
    input  dram_ctrl_pkg::bank_idx_t                            i_head_bank,
    input  logic                                                i_empty,
    // per-bank return channels
    input  logic [dram_ctrl_pkg::NUM_BANKS-1:0]                 i_bank_rdata_valid,
    input  dram_ctrl_pkg::word_t [dram_ctrl_pkg::NUM_BANKS-1:0] i_bank_rdata,
    output logic [dram_ctrl_pkg::NUM_BANKS-1:0]                 o_bank_ren,
    // front-end read data strobe
    output logic                                                o_read_data_valid,
    output dram_ctrl_pkg::word_t                                o_read_data,
    // retire the head entry
    output logic                                                o_pop
);

    // completed return per bank
    logic [dram_ctrl_pkg::NUM_BANKS-1:0] return_hs;

    ////////////////////////////////////////////////////////////
    // return enable
    ////////////////////////////////////////////////////////////

    // only the oldest read's bank may answer
    always_comb
    begin
        o_bank_ren = '0;
        if (i_rst_n && !i_empty)
        begin
            o_bank_ren[i_head_bank] = 1'b1;
        end
    end

    assign return_hs = o_bank_ren & i_bank_rdata_valid;

    ////////////////////////////////////////////////////////////
    // read data
    ////////////////////////////////////////////////////////////

    assign o_read_data_valid = |return_hs;

    // ren is one-hot so the head index picks the data
    assign o_read_data = o_read_data_valid ? i_bank_rdata[i_head_bank] : '0;

    // queue advances at the next edge
    assign o_pop = o_read_data_valid;

endmodule

/* source/read_order_fifo.sv */
module read_order_fifo
#(
    parameter int ORDER_DEPTH = 16
)
(
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_push,
    input  dram_ctrl_pkg::bank_idx_t i_push_bank,
    input  logic                     i_pop,
    output dram_ctrl_pkg::bank_idx_t o_head_bank,
    output logic                     o_empty,
    output logic                     o_full
);

    localparam int PTR_W = $clog2(ORDER_DEPTH);
    localparam int CNT_W = $clog2(ORDER_DEPTH + 1);

    // bank index storage
    dram_ctrl_pkg::bank_idx_t mem [ORDER_DEPTH];
    logic [PTR_W-1:0]         wr_ptr;
    logic [PTR_W-1:0]         rd_ptr;
    logic [CNT_W-1:0]         count;
    logic                     push_en;
    logic                     pop_en;

    // guard against overflow and underflow
    assign push_en = i_push && !o_full;
    assign pop_en  = i_pop && !o_empty;

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (push_en)
        begin
            mem[wr_ptr] <= i_push_bank;
        end
    end

    ////////////////////////////////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            // explicit wrap, depth need not be a power of two
            if (push_en)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(ORDER_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_en)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(ORDER_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves count alone
            case ({push_en, pop_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // oldest outstanding read
    assign o_head_bank = mem[rd_ptr];
    assign o_empty     = (count == '0);
    assign o_full      = (count == CNT_W'(ORDER_DEPTH));

endmodule

/* source/command_dispatch.sv */
module command_dispatch
(
    input  logic                                                   i_rst_n,
    // front-end request
    input  logic                                                   i_command_valid,
    input  dram_ctrl_pkg::frontend_command_t                       i_command,
    input  dram_ctrl_pkg::word_t                                   i_write_data,
    input  logic [dram_ctrl_pkg::NUM_BANKS-1:0]                    i_bank_ready,
    // read-order queue back-pressure
    input  logic                                                   i_order_full,
    output logic                                                   o_controller_ready,
    // per-bank command channels
    output logic [dram_ctrl_pkg::NUM_BANKS-1:0]                    o_bank_cmd_valid,
    output dram_ctrl_pkg::backend_command_t [dram_ctrl_pkg::NUM_BANKS-1:0] o_bank_cmd,
    output dram_ctrl_pkg::word_t [dram_ctrl_pkg::NUM_BANKS-1:0]    o_bank_wdata,
    // read-order queue push
    output logic                                                   o_order_push,
    output dram_ctrl_pkg::bank_idx_t                               o_order_bank
);

    // target bank from the low address bits
    dram_ctrl_pkg::bank_idx_t         target_bank;
    // address reshaped for the banks
    dram_ctrl_pkg::backend_command_t  bank_cmd;
    logic                             accept;

    assign target_bank = i_command.addr[dram_ctrl_pkg::BANK_BITS-1:0];

    // row from the top bits, column just above the bank index
    assign bank_cmd.op        = i_command.op;
    assign bank_cmd.data_type = i_command.data_type;
    assign bank_cmd.row_addr  =
        i_command.addr[dram_ctrl_pkg::ADDR_BITS-1 -: dram_ctrl_pkg::ROW_BITS];
    assign bank_cmd.col_addr  =
        i_command.addr[dram_ctrl_pkg::BANK_BITS +: dram_ctrl_pkg::COL_BITS];

    ////////////////////////////////////////////////////////////
    // acceptance
    ////////////////////////////////////////////////////////////

    // full queue stalls writes too, keeps ordering simple
    assign accept = i_rst_n && i_command_valid && !i_order_full
                    && i_bank_ready[target_bank];

    // ready only ever reflects a completed transfer
    assign o_controller_ready = accept;

    // one-hot valid toward the target bank
    always_comb
    begin
        o_bank_cmd_valid = '0;
        if (accept)
        begin
            o_bank_cmd_valid[target_bank] = 1'b1;
        end
    end

    // command and data broadcast, only the valid selects
    assign o_bank_cmd   = {dram_ctrl_pkg::NUM_BANKS{bank_cmd}};
    assign o_bank_wdata = {dram_ctrl_pkg::NUM_BANKS{i_write_data}};

    // remember the bank of each accepted read
    assign o_order_push = accept && (i_command.op == dram_ctrl_pkg::OP_READ);
    assign o_order_bank = target_bank;

endmodule

/* source/dram_ctrl_pkg.sv */
package dram_ctrl_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    // data word on both write and read paths
    localparam int WORD_SIZE = 32;
    // front-end byte-free word address
    localparam int ADDR_BITS = 22;
    // bank index sits in addr[1:0]
    localparam int BANK_BITS = 2;
    localparam int NUM_BANKS = 1 << BANK_BITS;
    // row is addr[21:6], column is addr[5:2]
    localparam int ROW_BITS  = 16;
    localparam int COL_BITS  = 4;

    ////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } op_e;

    typedef enum logic {
        DATA_TYPE_WEIGHTS  = 1'b0,
        DATA_TYPE_FEATURES = 1'b1
    } data_type_e;

    typedef logic [BANK_BITS-1:0] bank_idx_t;
    typedef logic [WORD_SIZE-1:0] word_t;

    // request as seen on the front end, 24 bits
    typedef struct packed {
        op_e                  op;
        data_type_e           data_type;
        logic [ADDR_BITS-1:0] addr;
    } frontend_command_t;

    // command handed to a bank controller, 22 bits
    typedef struct packed {
        op_e                 op;
        data_type_e          data_type;
        logic [ROW_BITS-1:0] row_addr;
        logic [COL_BITS-1:0] col_addr;
    } backend_command_t;

endpackage
